/* compile.f */
+incdir+source
source/len5_pkg.sv
source/expipe_pkg.sv
source/int_rf.sv
source/issue_stage.sv
source/alu_exec_stage.sv
source/expipe_top.sv
tb/tb_expipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_expipe -Mdir obj_dir -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_expipe 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* source/alu_exec_stage.sv */
/*
 * ALU stage: ten RV32I integer operations and the result register.
 * The registered result drives the register file write port and the
 * write-back outputs alike. No back-pressure, a valid operand set
 * always produces a one-cycle write-back on the next cycle.
 */

`timescale 1ns/1ps
`include "len5_params.svh"

module alu_exec_stage
    import len5_pkg::*;
    import expipe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // From the operand register
    input  logic     ex_valid_i,
    input  alu_op_t  ex_op_i,
    input  xlen_t    ex_opa_i,
    input  xlen_t    ex_opb_i,
    input  reg_idx_t ex_rd_idx_i,

    // Register file write port
    output logic     comm_valid_o,
    output reg_idx_t comm_rd_idx_o,
    output xlen_t    comm_rd_value_o,

    // Write-back outputs
    output logic     wb_valid_o,
    output reg_idx_t wb_rd_idx_o,
    output xlen_t    wb_value_o
);

    logic [SHAMT_LEN-1:0] shamt;
    xlen_t                alu_res;

    // Result register
    logic                 res_valid_q;
    reg_idx_t             res_rd_idx_q;
    xlen_t                res_value_q;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    // Only the low bits of b count for shifts
    assign shamt = ex_opb_i[SHAMT_LEN-1:0];

    always_comb begin
        unique case (ex_op_i)
            ALU_ADD:  alu_res = ex_opa_i + ex_opb_i;
            ALU_SUB:  alu_res = ex_opa_i - ex_opb_i;
            ALU_AND:  alu_res = ex_opa_i & ex_opb_i;
            ALU_OR:   alu_res = ex_opa_i | ex_opb_i;
            ALU_XOR:  alu_res = ex_opa_i ^ ex_opb_i;
            ALU_SLL:  alu_res = ex_opa_i << shamt;
            ALU_SRL:  alu_res = ex_opa_i >> shamt;
            // Sign bit fills from the left
            ALU_SRA:  alu_res = xlen_t'($signed(ex_opa_i) >>> shamt);
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, ($signed(ex_opa_i) < $signed(ex_opb_i))};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, (ex_opa_i < ex_opb_i)};
            // Unused encodings give zero
            default:  alu_res = '0;
        endcase
    end

    // ----------------------------------------------------------
    // Result register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= ex_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            res_rd_idx_q <= ex_rd_idx_i;
            res_value_q  <= alu_res;
        end
    end

    // Same registered values on commit and write-back
    assign comm_valid_o    = res_valid_q;
    assign comm_rd_idx_o   = res_rd_idx_q;
    assign comm_rd_value_o = res_value_q;

    assign wb_valid_o      = res_valid_q;
    assign wb_rd_idx_o     = res_rd_idx_q;
    assign wb_value_o      = res_value_q;

    // An X here would corrupt both commit and hazard checking upstream
    a_wb_valid_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            !$isunknown(wb_valid_o)
    ) else $error("wb_valid_o is unknown after reset");

endmodule

/* source/expipe_pkg.sv */
/*
 * Execution pipeline types.
 * The opcode set covers the RV32I register/immediate ALU operations
 * only. Shifts use the low SHAMT_LEN bits of operand b.
 */

`include "len5_params.svh"

package expipe_pkg;

    // ----------------------------------------------------------
    // ALU opcode
    // ----------------------------------------------------------
    // Opcode field width
    localparam int unsigned ALU_OP_LEN = 4;

    // Shift amount width, enough to shift across a full word
    localparam int unsigned SHAMT_LEN = $clog2(`XLEN);

    typedef enum logic [ALU_OP_LEN-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        // Logical and arithmetic shifts
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        // Set-less-than, result is 1 or 0
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

endpackage

/* source/expipe_top.sv */
/*
 * Integer execution slice top level: issue stage, register file and
 * ALU stage. Hazards stall the instruction input, there is no other
 * back-pressure. Write-back is a one-cycle pulse per instruction, in
 * program order, and cannot be stalled.
 */

`timescale 1ns/1ps
`include "len5_params.svh"

module expipe_top
    import len5_pkg::*;
    import expipe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Instruction input
    input  logic     instr_valid_i,
    output logic     instr_ready_o,
    input  alu_op_t  instr_op_i,
    input  logic     instr_use_imm_i,
    input  imm_t     instr_imm_i,
    input  reg_idx_t instr_rs1_idx_i,
    input  reg_idx_t instr_rs2_idx_i,
    input  reg_idx_t instr_rd_idx_i,

    // Write-back output
    output logic     wb_valid_o,
    output reg_idx_t wb_rd_idx_o,
    output xlen_t    wb_value_o
);

    // Operand read
    reg_idx_t issue_rs1_idx;
    reg_idx_t issue_rs2_idx;
    xlen_t    issue_rs1_value;
    xlen_t    issue_rs2_value;

    // Issue to execute
    logic     ex_valid;
    alu_op_t  ex_op;
    xlen_t    ex_opa;
    xlen_t    ex_opb;
    reg_idx_t ex_rd_idx;

    // Commit, also fed back for hazard checks
    logic     comm_valid;
    reg_idx_t comm_rd_idx;
    xlen_t    comm_rd_value;

    // ----------------------------------------------------------
    // Pipeline stages
    // ----------------------------------------------------------
    issue_stage u_issue_stage (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .instr_valid_i     (instr_valid_i),
        .instr_ready_o     (instr_ready_o),
        .instr_op_i        (instr_op_i),
        .instr_use_imm_i   (instr_use_imm_i),
        .instr_imm_i       (instr_imm_i),
        .instr_rs1_idx_i   (instr_rs1_idx_i),
        .instr_rs2_idx_i   (instr_rs2_idx_i),
        .instr_rd_idx_i    (instr_rd_idx_i),
        .issue_rs1_idx_o   (issue_rs1_idx),
        .issue_rs2_idx_o   (issue_rs2_idx),
        .issue_rs1_value_i (issue_rs1_value),
        .issue_rs2_value_i (issue_rs2_value),
        .cm_valid_i        (comm_valid),
        .cm_rd_idx_i       (comm_rd_idx),
        .ex_valid_o        (ex_valid),
        .ex_op_o           (ex_op),
        .ex_opa_o          (ex_opa),
        .ex_opb_o          (ex_opb),
        .ex_rd_idx_o       (ex_rd_idx)
    );

    int_rf u_int_rf (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .comm_valid_i      (comm_valid),
        .comm_rd_idx_i     (comm_rd_idx),
        .comm_rd_value_i   (comm_rd_value),
        .issue_rs1_idx_i   (issue_rs1_idx),
        .issue_rs2_idx_i   (issue_rs2_idx),
        .issue_rs1_value_o (issue_rs1_value),
        .issue_rs2_value_o (issue_rs2_value)
    );

    alu_exec_stage u_alu_exec_stage (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ex_valid_i        (ex_valid),
        .ex_op_i           (ex_op),
        .ex_opa_i          (ex_opa),
        .ex_opb_i          (ex_opb),
        .ex_rd_idx_i       (ex_rd_idx),
        .comm_valid_o      (comm_valid),
        .comm_rd_idx_o     (comm_rd_idx),
        .comm_rd_value_o   (comm_rd_value),
        .wb_valid_o        (wb_valid_o),
        .wb_rd_idx_o       (wb_rd_idx_o),
        .wb_value_o        (wb_value_o)
    );

endmodule

/* source/int_rf.sv */
/*
 * Integer register file, two combinational reads and one write.
 * x0 has no storage and reads as zero; writes to it are dropped.
 * A read of the register being written in the same cycle returns
 * the old value, no write-to-read bypass.
 */

`timescale 1ns/1ps
`include "len5_params.svh"

module int_rf import len5_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Write port from the commit side
    input  logic     comm_valid_i,
    input  reg_idx_t comm_rd_idx_i,
    input  xlen_t    comm_rd_value_i,

    // Read ports toward the issue stage
    input  reg_idx_t issue_rs1_idx_i,
    input  reg_idx_t issue_rs2_idx_i,
    output xlen_t    issue_rs1_value_o,
    output xlen_t    issue_rs2_value_o
);

    // Storage for x1 upward only
    xlen_t rf_data [1:`XREG_NUM-1];

    // ----------------------------------------------------------
    // Write port
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // All registers come out of reset as zero
            for (int i = 1; i < `XREG_NUM; i++) begin
                rf_data[i] <= '0;
            end
        end else if (comm_valid_i && (comm_rd_idx_i != '0)) begin
            rf_data[comm_rd_idx_i] <= comm_rd_value_i;
        end
    end

    // ----------------------------------------------------------
    // Read ports
    // ----------------------------------------------------------
    // Index 0 never reaches the array
    assign issue_rs1_value_o = (issue_rs1_idx_i == '0) ? '0 : rf_data[issue_rs1_idx_i];
    assign issue_rs2_value_o = (issue_rs2_idx_i == '0) ? '0 : rf_data[issue_rs2_idx_i];

    // A committed value is visible on both ports in the following cycle
    a_write_reads_back: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            (comm_valid_i && (comm_rd_idx_i != '0)) |=>
                (((issue_rs1_idx_i != $past(comm_rd_idx_i)) ||
                  (issue_rs1_value_o == $past(comm_rd_value_i))) &&
                 ((issue_rs2_idx_i != $past(comm_rd_idx_i)) ||
                  (issue_rs2_value_o == $past(comm_rd_value_i))))
    ) else $error("committed value did not read back in the next cycle");

endmodule

/* source/issue_stage.sv */
/*
 * Issue stage: instruction handshake, RAW hazard check, operand read
 * and operand register. No forwarding, a source that matches an
 * in-flight destination stalls until that result has been written.
 * The source must hold all instruction fields while valid and !ready.
 */

`timescale 1ns/1ps
`include "len5_params.svh"

module issue_stage
    import len5_pkg::*;
    import expipe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Instruction input
    input  logic     instr_valid_i,
    output logic     instr_ready_o,
    input  alu_op_t  instr_op_i,
    input  logic     instr_use_imm_i,
    input  imm_t     instr_imm_i,
    input  reg_idx_t instr_rs1_idx_i,
    input  reg_idx_t instr_rs2_idx_i,
    input  reg_idx_t instr_rd_idx_i,

    // Register file read ports
    output reg_idx_t issue_rs1_idx_o,
    output reg_idx_t issue_rs2_idx_o,
    input  xlen_t    issue_rs1_value_i,
    input  xlen_t    issue_rs2_value_i,

    // Result register of the ALU stage, for hazard checking
    input  logic     cm_valid_i,
    input  reg_idx_t cm_rd_idx_i,

    // Toward the ALU stage
    output logic     ex_valid_o,
    output alu_op_t  ex_op_o,
    output xlen_t    ex_opa_o,
    output xlen_t    ex_opb_o,
    output reg_idx_t ex_rd_idx_o
);

    // Operand register
    logic     ex_valid_q;
    alu_op_t  ex_op_q;
    xlen_t    ex_opa_q;
    xlen_t    ex_opb_q;
    reg_idx_t ex_rd_idx_q;

    // Hazard detection
    logic     rs1_hazard;
    logic     rs2_hazard;
    logic     hazard;
    logic     instr_hs;

    // Operand b selection
    xlen_t    imm_sext;
    xlen_t    opb_sel;

    // ----------------------------------------------------------
    // RAW hazard check
    // ----------------------------------------------------------
    // x0 never conflicts; rs2 only matters for register-register ops
    assign rs1_hazard = (instr_rs1_idx_i != '0) &&
                        ((ex_valid_q && (instr_rs1_idx_i == ex_rd_idx_q)) ||
                         (cm_valid_i && (instr_rs1_idx_i == cm_rd_idx_i)));
    assign rs2_hazard = !instr_use_imm_i && (instr_rs2_idx_i != '0) &&
                        ((ex_valid_q && (instr_rs2_idx_i == ex_rd_idx_q)) ||
                         (cm_valid_i && (instr_rs2_idx_i == cm_rd_idx_i)));
    assign hazard     = rs1_hazard || rs2_hazard;

    // Ready looks at the fields only, never at valid
    assign instr_ready_o = !hazard;
    assign instr_hs      = instr_valid_i && instr_ready_o;

    // ----------------------------------------------------------
    // Operand read and selection
    // ----------------------------------------------------------
    assign issue_rs1_idx_o = instr_rs1_idx_i;
    assign issue_rs2_idx_o = instr_rs2_idx_i;

    // Replicate the immediate sign bit up to XLEN
    assign imm_sext = {{(`XLEN-`IMM_LEN){instr_imm_i[`IMM_LEN-1]}}, instr_imm_i};
    assign opb_sel  = instr_use_imm_i ? imm_sext : issue_rs2_value_i;

    // ----------------------------------------------------------
    // Operand register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else begin
            // Bubble whenever nothing is accepted
            ex_valid_q <= instr_hs;
        end
    end

    // Payload only moves on a handshake
    always_ff @(posedge clk_i) begin
        if (instr_hs) begin
            ex_op_q     <= instr_op_i;
            ex_opa_q    <= issue_rs1_value_i;
            ex_opb_q    <= opb_sel;
            ex_rd_idx_q <= instr_rd_idx_i;
        end
    end

    assign ex_valid_o  = ex_valid_q;
    assign ex_op_o     = ex_op_q;
    assign ex_opa_o    = ex_opa_q;
    assign ex_opb_o    = ex_opb_q;
    assign ex_rd_idx_o = ex_rd_idx_q;

    // An older instruction must not commit to a source after it was read
    a_no_stale_rs1: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            (instr_hs && (instr_rs1_idx_i != '0)) |=>
                !(cm_valid_i && (cm_rd_idx_i == $past(instr_rs1_idx_i)))
    ) else $error("operand register loaded rs1 while a RAW hazard was present");

    a_no_stale_rs2: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            (instr_hs && !instr_use_imm_i && (instr_rs2_idx_i != '0)) |=>
                !(cm_valid_i && (cm_rd_idx_i == $past(instr_rs2_idx_i)))
    ) else $error("operand register loaded rs2 while a RAW hazard was present");

endmodule

/* source/len5_params.svh */
/*
 * Architectural sizes of the integer execution slice.
 * XLEN and XREG_NUM follow RV32I; the register index width must
 * cover XREG_NUM. Immediates are IMM_LEN bits wide and are always
 * sign-extended to XLEN by the issue stage.
 */

`ifndef LEN5_PARAMS_SVH
`define LEN5_PARAMS_SVH

// ----------------------------------------------------------
// Datapath sizes
// ----------------------------------------------------------
// Data word width
`define XLEN 32

// Integer register count, x0 included
`define XREG_NUM 32
// Bits needed to address one register
`define REG_IDX_LEN 5

// Raw I-type immediate width
`define IMM_LEN 12

`endif

/* source/len5_pkg.sv */
/*
 * Architectural types shared by the RTL and the testbench.
 * Widths come from the params header; change them there only.
 */

`include "len5_params.svh"

package len5_pkg;

    // ----------------------------------------------------------
    // Data and index types
    // ----------------------------------------------------------
    // One integer data word
    typedef logic [`XLEN-1:0] xlen_t;

    // One register file index
    typedef logic [`REG_IDX_LEN-1:0] reg_idx_t;

    // Immediate as it arrives with the instruction, not yet extended
    typedef logic [`IMM_LEN-1:0] imm_t;

endpackage

/* tb/tb_expipe.sv */
/*
 * Testbench for the integer execution slice.
 * A sequential register model predicts each write-back in program
 * order; the stall logic must make the pipeline match it exactly.
 * Random stimulus uses register indices 0 to 5 to force hazards.
 */

`timescale 1ns/1ps
`include "len5_params.svh"

module tb_expipe
    import len5_pkg::*;
    import expipe_pkg::*;
();

    // 31 + 15 + 9 + 3 + 12 + 200 instructions over all tests
    localparam int NUM_INSTR      = 270;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 200;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    logic     instr_ready;
    alu_op_t  instr_op;
    logic     instr_use_imm;
    imm_t     instr_imm;
    reg_idx_t instr_rs1;
    reg_idx_t instr_rs2;
    reg_idx_t instr_rd;
    logic     wb_valid;
    reg_idx_t wb_rd_idx;
    xlen_t    wb_value;

    // Reference register file and expected write-backs
    xlen_t    model_rf [0:`XREG_NUM-1];
    reg_idx_t exp_rd_q [$];
    xlen_t    exp_val_q [$];

    int main_errs;
    int main_checks;
    int mon_errs;
    int mon_checks;
    int issued_cnt;
    int cycle_cnt;
    int base_errs;
    int base_checks;

    expipe_top DUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .instr_valid_i   (instr_valid),
        .instr_ready_o   (instr_ready),
        .instr_op_i      (instr_op),
        .instr_use_imm_i (instr_use_imm),
        .instr_imm_i     (instr_imm),
        .instr_rs1_idx_i (instr_rs1),
        .instr_rs2_idx_i (instr_rs2),
        .instr_rd_idx_i  (instr_rd),
        .wb_valid_o      (wb_valid),
        .wb_rd_idx_o     (wb_rd_idx),
        .wb_value_o      (wb_value)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic xlen_t sext_imm(input imm_t imm);
        int v;
        v = int'(imm);
        // Negative when the top immediate bit is set
        if (imm[`IMM_LEN-1]) v = v - (1 << `IMM_LEN);
        return xlen_t'(v);
    endfunction

    function automatic xlen_t ref_alu(input alu_op_t op, input xlen_t a, input xlen_t b);
        logic [4:0] sh;
        xlen_t      ones;
        xlen_t      res;
        sh   = b[4:0];
        ones = '1;
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a + (~b + xlen_t'(1));
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << sh;
            ALU_SRL:  res = a >> sh;
            // Logical shift, then fill vacated top bits with the sign
            ALU_SRA:  res = a[31] ? ((a >> sh) | ~(ones >> sh)) : (a >> sh);
            // Differing signs decide directly, equal signs compare as unsigned
            ALU_SLT:  res = (a[31] != b[31]) ? xlen_t'(a[31]) : ((a < b) ? xlen_t'(1) : '0);
            ALU_SLTU: res = (a < b) ? xlen_t'(1) : '0;
            default:  res = '0;
        endcase
        return res;
    endfunction

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    // Called on a rising edge; returns on the handshake edge
    task automatic send_instr(input alu_op_t op, input logic use_imm, input imm_t imm,
                              input reg_idx_t rs1, input reg_idx_t rs2, input reg_idx_t rd);
        logic  accepted;
        xlen_t opb;
        xlen_t result;
        instr_valid   <= 1'b1;
        instr_op      <= op;
        instr_use_imm <= use_imm;
        instr_imm     <= imm;
        instr_rs1     <= rs1;
        instr_rs2     <= rs2;
        instr_rd      <= rd;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = instr_ready;
            @(posedge clk);
        end
        // Architectural result in program order
        opb    = use_imm ? sext_imm(imm) : model_rf[rs2];
        result = ref_alu(op, model_rf[rs1], opb);
        if (rd != '0) model_rf[rd] = result;
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(result);
        issued_cnt++;
    endtask

    task automatic drain_pipeline();
        instr_valid <= 1'b0;
        while (exp_rd_q.size() != 0) @(posedge clk);
        // Idle edges catch stray write-backs
        repeat (2) @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %0d checks, %0d errors", num, name,
                 main_checks + mon_checks - base_checks, main_errs + mon_errs - base_errs);
        base_checks = main_checks + mon_checks;
        base_errs   = main_errs + mon_errs;
    endtask

    // ----------------------------------------------------------
    // Write-back checker
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("Write-back to x%0d at %0t with no instruction outstanding",
                         wb_rd_idx, $time);
                mon_errs++;
            end else begin
                mon_checks++;
                assert (wb_rd_idx === exp_rd_q[0]) else begin
                    $display("** Error at %0t: write-back rd x%0d, expected x%0d",
                             $time, wb_rd_idx, exp_rd_q[0]);
                    mon_errs++;
                end
                assert (wb_value === exp_val_q[0]) else begin
                    $display("** Error at %0t: x%0d value %h, expected %h",
                             $time, wb_rd_idx, wb_value, exp_val_q[0]);
                    mon_errs++;
                end
                void'(exp_rd_q.pop_front());
                void'(exp_val_q.pop_front());
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d write-backs never arrived",
                     cycle_cnt, exp_rd_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        logic [3:0] op_bits;
        void'($urandom(32'hf415));
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr_op = ALU_ADD;
        instr_use_imm = 1'b0;
        instr_imm = '0;
        instr_rs1 = '0;
        instr_rs2 = '0;
        instr_rd = '0;
        for (int i = 0; i < `XREG_NUM; i++) model_rf[i] = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Idle outputs, then every register read back through x0
        @(negedge clk);
        main_checks += 2;
        assert (wb_valid === 1'b0) else begin
            $display("** Error at %0t: wb_valid_o high after reset", $time);
            main_errs++;
        end
        assert (instr_ready === 1'b1) else begin
            $display("** Error at %0t: instr_ready_o low after reset", $time);
            main_errs++;
        end
        @(posedge clk);
        for (int r = 1; r < `XREG_NUM; r++) begin
            send_instr(ALU_ADD, 1'b0, '0, reg_idx_t'(r), 5'd0, reg_idx_t'(r));
        end
        drain_pipeline();
        report_test(1, "reset state");

        // x1 = -8, x2 = 3, x3 = 1000
        send_instr(ALU_ADD, 1'b1, 12'hFF8, 5'd0, 5'd0, 5'd1);
        send_instr(ALU_ADD, 1'b1, 12'h003, 5'd0, 5'd0, 5'd2);
        send_instr(ALU_ADD, 1'b1, 12'h3E8, 5'd0, 5'd0, 5'd3);
        for (int k = 0; k < 10; k++) begin
            send_instr(alu_op_t'(4'(k)), 1'b0, '0, 5'd1, 5'd2, reg_idx_t'(10 + k));
        end
        send_instr(ALU_SLT, 1'b0, '0, 5'd2, 5'd1, 5'd20);
        send_instr(ALU_SLTU, 1'b0, '0, 5'd2, 5'd1, 5'd21);
        drain_pipeline();
        report_test(2, "register-register opcodes");

        send_instr(ALU_ADD, 1'b1, 12'hFFF, 5'd3, 5'd0, 5'd5);
        send_instr(ALU_ADD, 1'b1, 12'hFFF, 5'd5, 5'd0, 5'd5);
        send_instr(ALU_AND, 1'b1, 12'hFF0, 5'd1, 5'd0, 5'd11);
        send_instr(ALU_OR, 1'b1, 12'h800, 5'd2, 5'd0, 5'd12);
        send_instr(ALU_XOR, 1'b1, 12'hFFF, 5'd3, 5'd0, 5'd13);
        send_instr(ALU_SLT, 1'b1, 12'hFFF, 5'd1, 5'd0, 5'd14);
        send_instr(ALU_SLTU, 1'b1, 12'hFFF, 5'd2, 5'd0, 5'd15);
        send_instr(ALU_SRA, 1'b1, 12'h002, 5'd1, 5'd0, 5'd16);
        send_instr(ALU_SLL, 1'b1, 12'h01F, 5'd2, 5'd0, 5'd17);
        drain_pipeline();
        report_test(3, "immediate forms");

        // Result shows on x0 and commits before x0 is read again
        send_instr(ALU_ADD, 1'b0, '0, 5'd3, 5'd2, 5'd0);
        drain_pipeline();
        send_instr(ALU_ADD, 1'b0, '0, 5'd0, 5'd0, 5'd6);
        send_instr(ALU_OR, 1'b0, '0, 5'd0, 5'd3, 5'd7);
        drain_pipeline();
        report_test(4, "x0 writes");

        // Each step needs the previous result
        send_instr(ALU_ADD, 1'b1, 12'h001, 5'd0, 5'd0, 5'd8);
        repeat (8) send_instr(ALU_ADD, 1'b0, '0, 5'd8, 5'd8, 5'd8);
        send_instr(ALU_SUB, 1'b0, '0, 5'd8, 5'd2, 5'd9);
        send_instr(ALU_XOR, 1'b0, '0, 5'd9, 5'd8, 5'd9);
        send_instr(ALU_SRA, 1'b0, '0, 5'd9, 5'd2, 5'd9);
        drain_pipeline();
        report_test(5, "dependent chain");

        for (int n = 0; n < 200; n++) begin
            op_bits = 4'($urandom_range(9, 0));
            send_instr(alu_op_t'(op_bits), 1'($urandom), imm_t'($urandom),
                       reg_idx_t'($urandom_range(5, 0)), reg_idx_t'($urandom_range(5, 0)),
                       reg_idx_t'($urandom_range(5, 0)));
        end
        drain_pipeline();
        report_test(6, "random hazards");

        $display("Done: %0d instructions, %0d checks, %0d errors",
                 issued_cnt, main_checks + mon_checks, main_errs + mon_errs);
        if (main_errs + mon_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
